//--- src/isa_pkg.sv
`default_nettype none

package isa_pkg;

    typedef logic [4:0]  reg_addr_t;
    typedef logic [31:0] word_t;

    typedef enum logic [3:0] {
        CLS_NOP    = 4'd0,
        CLS_LUI    = 4'd1,
        CLS_AUIPC  = 4'd2,
        CLS_JAL    = 4'd3,
        CLS_JALR   = 4'd4,
        CLS_BRANCH = 4'd5,
        CLS_LOAD   = 4'd6,
        CLS_STORE  = 4'd7,
        CLS_OP_IMM = 4'd8,
        CLS_OP     = 4'd9
    } op_class_e;

    // {funct7[5], funct3}
    typedef enum logic [3:0] {
        ALU_ADD  = 4'b0000,
        ALU_SLL  = 4'b0001,
        ALU_SLT  = 4'b0010,
        ALU_SLTU = 4'b0011,
        ALU_XOR  = 4'b0100,
        ALU_SRL  = 4'b0101,
        ALU_OR   = 4'b0110,
        ALU_AND  = 4'b0111,
        ALU_SUB  = 4'b1000,
        ALU_SRA  = 4'b1101
    } alu_sel_e;

    // funct3 of the branch
    typedef enum logic [3:0] {
        BR_BEQ  = 4'b0000,
        BR_BNE  = 4'b0001,
        BR_BLT  = 4'b0100,
        BR_BGE  = 4'b0101,
        BR_BLTU = 4'b0110,
        BR_BGEU = 4'b0111
    } br_cond_e;

    // funct3 of the load/store
    typedef enum logic [3:0] {
        MEM_B  = 4'b0000,
        MEM_H  = 4'b0001,
        MEM_W  = 4'b0010,
        MEM_BU = 4'b0100,
        MEM_HU = 4'b0101
    } mem_size_e;

    // one selector field, meaning depends on op class
    typedef union packed {
        alu_sel_e  alu;
        br_cond_e  cond;
        mem_size_e size;
    } op_sel_u;

endpackage

`default_nettype wire

//--- src/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

    import isa_pkg::*;

    // decoded instruction from decode
    typedef struct packed {
        logic      valid;
        op_class_e op_class;
        op_sel_u   op_sel;
        word_t     pc;
        word_t     imm;
        reg_addr_t rs1;
        reg_addr_t rs2;
        word_t     rs1_val;
        word_t     rs2_val;
        reg_addr_t rd;
        logic      rd_we;
    } issue_t;

    // execute result towards the memory stage
    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        logic      rd_we;
        word_t     result;
        logic      is_load;
        logic      is_store;
        mem_size_e mem_size;
        word_t     store_data;
    } ex_mem_t;

    typedef struct packed {
        logic  valid;
        word_t target;
    } redirect_t;

    typedef struct packed {
        logic      we;
        reg_addr_t rd;
        word_t     data;
    } wb_t;

endpackage

`default_nettype wire

//--- src/fwd_mux.sv
`timescale 1ns/1ps
`default_nettype none

module fwd_mux (
    input  wire pipe_pkg::ex_mem_t  ex_mem_i,
    input  wire pipe_pkg::wb_t      wb_i,
    input  wire isa_pkg::reg_addr_t rs_i,
    input  wire isa_pkg::word_t     rs_val_i,
    output isa_pkg::word_t          operand_o
);

    logic ex_hit;
    logic wb_hit;

    // loads resolve in the memory stage and are never bypassed from here
    assign ex_hit = ex_mem_i.valid && ex_mem_i.rd_we && !ex_mem_i.is_load &&
                    (ex_mem_i.rd != '0) && (ex_mem_i.rd == rs_i);
    assign wb_hit = wb_i.we && (wb_i.rd != '0) && (wb_i.rd == rs_i);

    always_comb begin
        if (rs_i == '0) begin
            operand_o = '0;
        end else if (ex_hit) begin
            operand_o = ex_mem_i.result;
        end else if (wb_hit) begin
            operand_o = wb_i.data;
        end else begin
            operand_o = rs_val_i;
        end
    end

endmodule

`default_nettype wire

//--- src/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  wire isa_pkg::alu_sel_e sel_i,
    input  wire isa_pkg::word_t    a_i,
    input  wire isa_pkg::word_t    b_i,
    output isa_pkg::word_t         result_o
);

    import isa_pkg::*;

    logic [4:0] shamt;
    logic       lt_s;
    logic       lt_u;

    assign shamt = b_i[4:0];
    assign lt_s  = $signed(a_i) < $signed(b_i);
    assign lt_u  = a_i < b_i;

    always_comb begin
        case (sel_i)
            ALU_ADD: begin
                result_o = a_i + b_i;
            end
            ALU_SUB: begin
                result_o = a_i - b_i;
            end
            ALU_SLL: begin
                result_o = a_i << shamt;
            end
            ALU_SLT: begin
                result_o = {31'b0, lt_s};
            end
            ALU_SLTU: begin
                result_o = {31'b0, lt_u};
            end
            ALU_XOR: begin
                result_o = a_i ^ b_i;
            end
            ALU_SRL: begin
                result_o = a_i >> shamt;
            end
            ALU_SRA: begin
                // sign bit fills from the left
                result_o = $unsigned($signed(a_i) >>> shamt);
            end
            ALU_OR: begin
                result_o = a_i | b_i;
            end
            ALU_AND: begin
                result_o = a_i & b_i;
            end
            default: begin
                result_o = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- src/branch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module branch_unit (
    input  wire isa_pkg::op_class_e op_class_i,
    input  wire isa_pkg::br_cond_e  cond_i,
    input  wire isa_pkg::word_t     pc_i,
    input  wire isa_pkg::word_t     imm_i,
    input  wire isa_pkg::word_t     rs1_i,
    input  wire isa_pkg::word_t     rs2_i,
    output pipe_pkg::redirect_t     redirect_o
);

    import isa_pkg::*;

    logic  taken;
    word_t jalr_sum;

    assign jalr_sum = rs1_i + imm_i;

    always_comb begin
        case (cond_i)
            BR_BEQ:  taken = (rs1_i == rs2_i);
            BR_BNE:  taken = (rs1_i != rs2_i);
            BR_BLT:  taken = ($signed(rs1_i) < $signed(rs2_i));
            BR_BGE:  taken = ($signed(rs1_i) >= $signed(rs2_i));
            BR_BLTU: taken = (rs1_i < rs2_i);
            BR_BGEU: taken = (rs1_i >= rs2_i);
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        redirect_o.valid  = 1'b0;
        redirect_o.target = pc_i + imm_i;
        case (op_class_i)
            CLS_JAL: begin
                redirect_o.valid = 1'b1;
            end
            CLS_JALR: begin
                redirect_o.valid  = 1'b1;
                redirect_o.target = {jalr_sum[31:1], 1'b0};
            end
            CLS_BRANCH: begin
                redirect_o.valid = taken;
            end
            default: begin
                redirect_o.valid = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- src/ex_stage.sv
`timescale 1ns/1ps
`default_nettype none

module ex_stage (
    input  wire pipe_pkg::issue_t entry_i,
    input  wire isa_pkg::word_t   rs1_i,
    input  wire isa_pkg::word_t   rs2_i,
    output pipe_pkg::ex_mem_t     result_o,
    output pipe_pkg::redirect_t   redirect_o
);

    import isa_pkg::*;
    import pipe_pkg::*;

    word_t     alu_b;
    alu_sel_e  alu_sel;
    word_t     alu_result;
    redirect_t br_redirect;

    // operand b and op select, address generation uses ADD
    always_comb begin
        alu_b   = entry_i.imm;
        alu_sel = ALU_ADD;
        case (entry_i.op_class)
            CLS_OP: begin
                alu_b   = rs2_i;
                alu_sel = entry_i.op_sel.alu;
            end
            CLS_OP_IMM: begin
                alu_sel = entry_i.op_sel.alu;
            end
            default: begin
                alu_sel = ALU_ADD;
            end
        endcase
    end

    alu u_alu (
        .sel_i    (alu_sel),
        .a_i      (rs1_i),
        .b_i      (alu_b),
        .result_o (alu_result)
    );

    branch_unit u_branch (
        .op_class_i (entry_i.op_class),
        .cond_i     (entry_i.op_sel.cond),
        .pc_i       (entry_i.pc),
        .imm_i      (entry_i.imm),
        .rs1_i      (rs1_i),
        .rs2_i      (rs2_i),
        .redirect_o (br_redirect)
    );

    always_comb begin
        result_o.valid      = entry_i.valid;
        result_o.rd         = entry_i.rd;
        result_o.rd_we      = 1'b0;
        result_o.result     = alu_result;
        result_o.is_load    = 1'b0;
        result_o.is_store   = 1'b0;
        result_o.mem_size   = entry_i.op_sel.size;
        result_o.store_data = '0;
        case (entry_i.op_class)
            CLS_LUI: begin
                result_o.result = entry_i.imm;
                result_o.rd_we  = entry_i.rd_we;
            end
            CLS_AUIPC: begin
                result_o.result = entry_i.pc + entry_i.imm;
                result_o.rd_we  = entry_i.rd_we;
            end
            CLS_JAL, CLS_JALR: begin
                // link value
                result_o.result = entry_i.pc + 32'd4;
                result_o.rd_we  = entry_i.rd_we;
            end
            CLS_OP, CLS_OP_IMM: begin
                result_o.rd_we = entry_i.rd_we;
            end
            CLS_LOAD: begin
                // rd written by the memory stage
                result_o.is_load = 1'b1;
            end
            CLS_STORE: begin
                result_o.is_store   = 1'b1;
                result_o.store_data = rs2_i;
            end
            default: begin
                result_o.rd_we = 1'b0;
            end
        endcase
    end

    assign redirect_o.valid  = entry_i.valid && br_redirect.valid;
    assign redirect_o.target = br_redirect.target;

endmodule

`default_nettype wire

//--- src/ex_cluster.sv
`timescale 1ns/1ps
`default_nettype none

module ex_cluster (
    input  wire                   clk,
    input  wire                   reset_i,
    input  wire pipe_pkg::issue_t issue_i,
    input  wire pipe_pkg::wb_t    wb_i,
    output pipe_pkg::ex_mem_t     mem_o,
    output pipe_pkg::redirect_t   redirect_o,
    output pipe_pkg::wb_t         fwd_o
);

    import isa_pkg::*;
    import pipe_pkg::*;

    issue_t  id_ex_q;
    ex_mem_t ex_mem_q;
    ex_mem_t ex_mem_d;
    word_t   rs1_fwd;
    word_t   rs2_fwd;

    // ID/EX, a redirect kills the entry arriving behind it
    always_ff @(posedge clk) begin
        id_ex_q <= issue_i;
        if (reset_i) begin
            id_ex_q.valid <= 1'b0;
        end else if (redirect_o.valid) begin
            id_ex_q.valid <= 1'b0;
        end
    end

    fwd_mux u_fwd_rs1 (
        .ex_mem_i  (ex_mem_q),
        .wb_i      (wb_i),
        .rs_i      (id_ex_q.rs1),
        .rs_val_i  (id_ex_q.rs1_val),
        .operand_o (rs1_fwd)
    );

    fwd_mux u_fwd_rs2 (
        .ex_mem_i  (ex_mem_q),
        .wb_i      (wb_i),
        .rs_i      (id_ex_q.rs2),
        .rs_val_i  (id_ex_q.rs2_val),
        .operand_o (rs2_fwd)
    );

    ex_stage u_ex (
        .entry_i    (id_ex_q),
        .rs1_i      (rs1_fwd),
        .rs2_i      (rs2_fwd),
        .result_o   (ex_mem_d),
        .redirect_o (redirect_o)
    );

    // EX/MEM
    always_ff @(posedge clk) begin
        ex_mem_q <= ex_mem_d;
        if (reset_i) begin
            ex_mem_q.valid <= 1'b0;
        end
    end

    assign mem_o = ex_mem_q;

    // bypass offered to decode, loads excluded
    assign fwd_o.we   = ex_mem_q.valid && ex_mem_q.rd_we && !ex_mem_q.is_load;
    assign fwd_o.rd   = ex_mem_q.rd;
    assign fwd_o.data = ex_mem_q.result;

    a_load_store_excl : assert property (@(posedge clk) disable iff (reset_i)
        mem_o.valid |-> !(mem_o.is_load && mem_o.is_store));

    a_redirect_src : assert property (@(posedge clk) disable iff (reset_i)
        redirect_o.valid |-> id_ex_q.valid);

    // flushed slot never reaches EX/MEM
    a_flush_bubble : assert property (@(posedge clk) disable iff (reset_i)
        redirect_o.valid |=> ##1 !mem_o.valid);

endmodule

`default_nettype wire

//--- verif/ex_cluster_tests.svh
`ifndef EX_CLUSTER_TESTS_SVH
`define EX_CLUSTER_TESTS_SVH

task automatic test_reset();
    begin_test("reset");
    reset_i = 1'b1;
    // a jump held on the input must not survive reset
    issue_i = make_issue(CLS_JAL, 4'd0, 32'h100, 32'h40, 5'd0, 32'd0, 5'd0, 32'd0, 5'd1);
    repeat (RESET_CYCLES) @(negedge clk);
    check_value("redirect valid", 1'b0, redirect_o.valid);
    check_value("mem valid", 1'b0, mem_o.valid);
    issue_i = '0;
    reset_i = 1'b0;
    end_test();
endtask

task automatic test_reg_alu();
    alu_sel_e ops [10];
    issue_t   e;
    int       i;
    int       n;
    ops = '{ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
            ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND};
    begin_test("reg_alu");
    for (n = 0; n < 2; n++) begin
        for (i = 0; i < 10; i++) begin
            e = make_issue(CLS_OP, ops[i], rand_pc(), rand_word(), rand_reg(), rand_word(),
                           rand_reg(), rand_word(), rand_reg());
            run_one(e);
        end
    end
    end_test();
endtask

task automatic test_imm_upper();
    alu_sel_e ops [9];
    issue_t   e;
    int       i;
    ops = '{ALU_ADD, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_OR, ALU_AND, ALU_SLL, ALU_SRL, ALU_SRA};
    begin_test("imm_upper");
    for (i = 0; i < 9; i++) begin
        e = make_issue(CLS_OP_IMM, ops[i], rand_pc(), sext12(12'($urandom())), rand_reg(),
                       rand_word(), 5'd0, 32'd0, rand_reg());
        run_one(e);
    end
    e = make_issue(CLS_LUI, 4'd0, rand_pc(), rand_word() & 32'hffff_f000, 5'd0, 32'd0,
                   5'd0, 32'd0, rand_reg());
    run_one(e);
    e = make_issue(CLS_AUIPC, 4'd0, rand_pc(), rand_word() & 32'hffff_f000, 5'd0, 32'd0,
                   5'd0, 32'd0, rand_reg());
    run_one(e);
    end_test();
endtask

task automatic test_branches();
    br_cond_e conds [6];
    word_t    lhs [4];
    word_t    rhs [4];
    issue_t   e;
    word_t    pc;
    int       i;
    int       j;
    conds = '{BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU};
    // equal, less, negative against positive both ways
    lhs   = '{32'd5, 32'd5, 32'hffff_fff0, 32'd5};
    rhs   = '{32'd5, 32'd9, 32'd5, 32'hffff_fff0};
    begin_test("branches");
    for (i = 0; i < 6; i++) begin
        for (j = 0; j < 4; j++) begin
            pc = rand_pc();
            e  = make_issue(CLS_BRANCH, conds[i], pc, sext12(12'($urandom())) << 1,
                            rand_reg(), lhs[j], rand_reg(), rhs[j], rand_reg());
            run_pair(e, make_probe(pc + 32'd4));
        end
    end
    end_test();
endtask

task automatic test_jumps();
    issue_t e;
    word_t  pc;
    int     i;
    begin_test("jumps");
    for (i = 0; i < 2; i++) begin
        pc = rand_pc();
        e  = make_issue(CLS_JAL, 4'd0, pc, sext12(12'($urandom())) << 1, 5'd0, 32'd0,
                        5'd0, 32'd0, rand_reg());
        run_pair(e, make_probe(pc + 32'd4));
    end
    // even base with odd offset gives an odd sum
    pc = rand_pc();
    e  = make_issue(CLS_JALR, 4'd0, pc, sext12(12'($urandom())) | 32'd1, rand_reg(),
                    rand_word() & 32'hffff_fffe, 5'd0, 32'd0, rand_reg());
    run_pair(e, make_probe(pc + 32'd4));
    pc = rand_pc();
    e  = make_issue(CLS_JALR, 4'd0, pc, sext12(12'($urandom())), rand_reg(), rand_word(),
                    5'd0, 32'd0, rand_reg());
    run_pair(e, make_probe(pc + 32'd4));
    end_test();
endtask

task automatic test_mem();
    mem_size_e sizes [5];
    issue_t    e;
    int        i;
    sizes = '{MEM_B, MEM_H, MEM_W, MEM_BU, MEM_HU};
    begin_test("mem");
    for (i = 0; i < 5; i++) begin
        e = make_issue(CLS_LOAD, sizes[i], rand_pc(), sext12(12'($urandom())), rand_reg(),
                       rand_word(), 5'd0, 32'd0, rand_reg());
        run_one(e);
    end
    for (i = 0; i < 3; i++) begin
        e = make_issue(CLS_STORE, sizes[i], rand_pc(), sext12(12'($urandom())), rand_reg(),
                       rand_word(), rand_reg(), rand_word(), rand_reg());
        run_one(e);
    end
    end_test();
endtask

task automatic test_forwarding();
    issue_t first;
    issue_t second;
    word_t  stale;
    stale = 32'h0bad_f00d;
    begin_test("forwarding");
    // back-to-back dependent adds
    first  = make_issue(CLS_OP, ALU_ADD, 32'h200, 32'd0, 5'd1, rand_word(), 5'd2,
                        rand_word(), 5'd5);
    second = make_issue(CLS_OP, ALU_ADD, 32'h204, 32'd0, 5'd5, stale, 5'd3, rand_word(), 5'd6);
    run_pair(first, second);
    // rs1 from writeback, rs2 from EX/MEM
    wb_i.we   = 1'b1;
    wb_i.rd   = 5'd7;
    wb_i.data = rand_word();
    first  = make_issue(CLS_OP, ALU_ADD, 32'h300, 32'd0, 5'd1, rand_word(), 5'd2,
                        rand_word(), 5'd9);
    second = make_issue(CLS_OP, ALU_XOR, 32'h304, 32'd0, 5'd7, stale, 5'd9, stale, 5'd8);
    run_pair(first, second);
    // x10 pending in both, the younger one wins
    wb_i.rd = 5'd10;
    first  = make_issue(CLS_OP_IMM, ALU_ADD, 32'h400, 32'd77, 5'd1, rand_word(), 5'd0,
                        32'd0, 5'd10);
    second = make_issue(CLS_OP, ALU_SUB, 32'h404, 32'd0, 5'd10, stale, 5'd3, rand_word(), 5'd11);
    run_pair(first, second);
    wb_i = '0;
    // load data is not ready in EX/MEM
    first  = make_issue(CLS_LOAD, MEM_W, 32'h500, 32'd8, 5'd1, rand_word(), 5'd0, 32'd0, 5'd12);
    second = make_issue(CLS_OP, ALU_ADD, 32'h504, 32'd0, 5'd12, rand_word(), 5'd2,
                        rand_word(), 5'd13);
    run_pair(first, second);
    // writes to x0 from both paths are ignored
    wb_i.we   = 1'b1;
    wb_i.rd   = 5'd0;
    wb_i.data = rand_word();
    first  = make_issue(CLS_OP_IMM, ALU_ADD, 32'h600, 32'd5, 5'd1, rand_word(), 5'd0,
                        32'd0, 5'd0);
    second = make_issue(CLS_OP, ALU_OR, 32'h604, 32'd0, 5'd0, stale, 5'd0, stale, 5'd14);
    run_pair(first, second);
    wb_i = '0;
    end_test();
endtask

`endif

//--- verif/ex_cluster_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ex_cluster_tb;

    import isa_pkg::*;
    import pipe_pkg::*;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 4;
    // every pair of issues takes four cycles from drive to last check
    localparam int PAIR_CYCLES  = 4;
    // reg_alu + imm_upper + branches + jumps + mem + forwarding
    localparam int PAIR_COUNT   = 20 + 11 + 24 + 4 + 8 + 5;
    localparam int LIMIT_CYCLES = RESET_CYCLES + PAIR_COUNT * PAIR_CYCLES + 20;

    logic      clk;
    logic      reset_i;
    issue_t    issue_i;
    wb_t       wb_i;
    ex_mem_t   mem_o;
    redirect_t redirect_o;
    wb_t       fwd_o;

    string       test_name;
    int          test_errors;
    int          test_count;
    int          check_count;
    int          error_count;

    ex_cluster uut (
        .clk        (clk),
        .reset_i    (reset_i),
        .issue_i    (issue_i),
        .wb_i       (wb_i),
        .mem_o      (mem_o),
        .redirect_o (redirect_o),
        .fwd_o      (fwd_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(LIMIT_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, tests did not finish", LIMIT_CYCLES);
        $display("Test failed");
        $finish;
    end

    function automatic word_t rand_word();
        return $urandom();
    endfunction

    function automatic reg_addr_t rand_reg();
        return 5'($urandom_range(31, 1));
    endfunction

    function automatic word_t rand_pc();
        return $urandom() & 32'hffff_fffc;
    endfunction

    function automatic word_t sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic issue_t make_issue(input op_class_e cls, input logic [3:0] sel,
                                          input word_t pc, input word_t imm,
                                          input reg_addr_t rs1, input word_t rs1_val,
                                          input reg_addr_t rs2, input word_t rs2_val,
                                          input reg_addr_t rd);
        issue_t e;
        e          = '0;
        e.valid    = 1'b1;
        e.op_class = cls;
        e.op_sel   = sel;
        e.pc       = pc;
        e.imm      = imm;
        e.rs1      = rs1;
        e.rs1_val  = rs1_val;
        e.rs2      = rs2;
        e.rs2_val  = rs2_val;
        e.rd       = rd;
        // decode may leave rd_we set and execute clears it where needed
        e.rd_we    = 1'b1;
        return e;
    endfunction

    // addi x30, x0, 1 issued behind a jump or branch
    function automatic issue_t make_probe(input word_t pc);
        return make_issue(CLS_OP_IMM, ALU_ADD, pc, 32'd1, 5'd0, 32'd0, 5'd0, 32'd0, 5'd30);
    endfunction

    function automatic word_t alu_ref(input alu_sel_e op, input word_t a, input word_t b);
        logic [63:0] ext;
        int          sh;
        sh  = b[4:0];
        ext = {{32{a[31]}}, a} >> sh;
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a + ~b + 32'd1;
            ALU_SLL:  return a << sh;
            ALU_SLT:  return ((a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)) ? 32'd1 : 32'd0;
            ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
            ALU_XOR:  return a ^ b;
            ALU_SRL:  return a >> sh;
            ALU_SRA:  return ext[31:0];
            ALU_OR:   return a | b;
            ALU_AND:  return a & b;
            default:  return 32'd0;
        endcase
    endfunction

    function automatic logic taken_ref(input br_cond_e c, input word_t a, input word_t b);
        logic lt_s;
        // different signs decide by the sign of a
        lt_s = (a[31] != b[31]) ? a[31] : (a < b);
        case (c)
            BR_BEQ:  return a == b;
            BR_BNE:  return a != b;
            BR_BLT:  return lt_s;
            BR_BGE:  return !lt_s;
            BR_BLTU: return a < b;
            BR_BGEU: return !(a < b);
            default: return 1'b0;
        endcase
    endfunction

    function automatic word_t resolve_operand(input reg_addr_t rs, input word_t val,
                                              input ex_mem_t ahead, input wb_t wb);
        if (rs == 5'd0) begin
            return 32'd0;
        end
        if (ahead.valid && ahead.rd_we && !ahead.is_load && ahead.rd == rs) begin
            return ahead.result;
        end
        if (wb.we && wb.rd == rs) begin
            return wb.data;
        end
        return val;
    endfunction

    task automatic predict(input issue_t e, input ex_mem_t ahead, input wb_t wb,
                           output ex_mem_t m, output redirect_t r);
        word_t a;
        word_t b;
        a       = resolve_operand(e.rs1, e.rs1_val, ahead, wb);
        b       = resolve_operand(e.rs2, e.rs2_val, ahead, wb);
        m       = '0;
        r       = '0;
        m.valid = e.valid;
        m.rd    = e.rd;
        case (e.op_class)
            CLS_LUI: begin
                m.result = e.imm;
                m.rd_we  = e.rd_we;
            end
            CLS_AUIPC: begin
                m.result = e.pc + e.imm;
                m.rd_we  = e.rd_we;
            end
            CLS_JAL: begin
                m.result = e.pc + 32'd4;
                m.rd_we  = e.rd_we;
                r.valid  = 1'b1;
                r.target = e.pc + e.imm;
            end
            CLS_JALR: begin
                m.result = e.pc + 32'd4;
                m.rd_we  = e.rd_we;
                r.valid  = 1'b1;
                r.target = (a + e.imm) & 32'hffff_fffe;
            end
            CLS_BRANCH: begin
                r.valid  = taken_ref(e.op_sel.cond, a, b);
                r.target = e.pc + e.imm;
            end
            CLS_LOAD: begin
                m.result   = a + e.imm;
                m.is_load  = 1'b1;
                m.mem_size = e.op_sel.size;
            end
            CLS_STORE: begin
                m.result     = a + e.imm;
                m.is_store   = 1'b1;
                m.mem_size   = e.op_sel.size;
                m.store_data = b;
            end
            CLS_OP: begin
                m.result = alu_ref(e.op_sel.alu, a, b);
                m.rd_we  = e.rd_we;
            end
            CLS_OP_IMM: begin
                m.result = alu_ref(e.op_sel.alu, a, e.imm);
                m.rd_we  = e.rd_we;
            end
            default: begin
                m.rd_we = 1'b0;
            end
        endcase
        r.valid = r.valid && e.valid;
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        assert (actual === expected) else begin
            $display("** Error %s: %s expected %h, actual %h", test_name, what, expected, actual);
            test_errors++;
        end
    endtask

    task automatic check_redirect(input redirect_t exp_r);
        check_value("redirect valid", exp_r.valid, redirect_o.valid);
        if (exp_r.valid) begin
            check_value("redirect target", exp_r.target, redirect_o.target);
        end
    endtask

    task automatic check_result(input issue_t e, input ex_mem_t exp_m);
        check_value("mem valid", exp_m.valid, mem_o.valid);
        if (exp_m.valid) begin
            check_value("rd_we", exp_m.rd_we, mem_o.rd_we);
            check_value("fwd we", exp_m.rd_we, fwd_o.we);
            if (exp_m.rd_we) begin
                check_value("rd", exp_m.rd, mem_o.rd);
                check_value("fwd rd", exp_m.rd, fwd_o.rd);
                check_value("fwd data", exp_m.result, fwd_o.data);
            end
            // branch result has no meaning
            if (e.op_class != CLS_BRANCH) begin
                check_value("result", exp_m.result, mem_o.result);
            end
            check_value("is_load", exp_m.is_load, mem_o.is_load);
            check_value("is_store", exp_m.is_store, mem_o.is_store);
            if (exp_m.is_load || exp_m.is_store) begin
                check_value("mem_size", exp_m.mem_size, mem_o.mem_size);
            end
            if (exp_m.is_store) begin
                check_value("store_data", exp_m.store_data, mem_o.store_data);
            end
        end
    endtask

    // first issue, then second right behind it, then bubbles until both are checked
    task automatic run_pair(input issue_t first, input issue_t second);
        ex_mem_t   idle;
        ex_mem_t   m1;
        ex_mem_t   m2;
        redirect_t r1;
        redirect_t r2;
        idle = '0;
        predict(first, idle, wb_i, m1, r1);
        @(negedge clk);
        issue_i = first;
        @(negedge clk);
        check_redirect(r1);
        issue_i = second;
        @(negedge clk);
        check_result(first, m1);
        if (r1.valid) begin
            // flushed by the redirect
            m2 = '0;
            r2 = '0;
        end else begin
            predict(second, m1, wb_i, m2, r2);
        end
        check_redirect(r2);
        issue_i = '0;
        @(negedge clk);
        check_result(second, m2);
    endtask

    task automatic run_one(input issue_t e);
        issue_t bubble;
        bubble = '0;
        run_pair(e, bubble);
    endtask

    task automatic begin_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        $display("%-12s errors %0d", test_name, test_errors);
        error_count += test_errors;
        test_count++;
    endtask

    `include "ex_cluster_tests.svh"

    initial begin
        void'($urandom(32'hdc31));
        reset_i     = 1'b1;
        issue_i     = '0;
        wb_i        = '0;
        test_errors = 0;
        test_count  = 0;
        check_count = 0;
        error_count = 0;
        test_reset();
        test_reg_alu();
        test_imm_upper();
        test_branches();
        test_jumps();
        test_mem();
        test_forwarding();
        $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
+incdir+verif
src/isa_pkg.sv
src/pipe_pkg.sv
src/fwd_mux.sv
src/alu.sv
src/branch_unit.sv
src/ex_stage.sv
src/ex_cluster.sv
verif/ex_cluster_tb.sv
